//--- files.f
+incdir+verif
hdl/rf_rx_pkg.sv
hdl/stream_pkg.sv
hdl/rx_cmos_if.sv
hdl/rf_ctrl.sv
hdl/axis_pack.sv
hdl/ad9361_dual.sv
verif/tb_ad9361_dual.sv

//--- hdl/ad9361_dual.sv
`default_nettype none

module ad9361_dual
  import rf_rx_pkg::*, stream_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  // receive a
  input  logic                a_rx_frame_in,
  input  logic [SAMPLE_W-1:0] a_rx_data_p0,
  input  logic [SAMPLE_W-1:0] a_rx_data_p1,
  // receive b
  input  logic                b_rx_frame_in,
  input  logic [SAMPLE_W-1:0] b_rx_data_p0,
  input  logic [SAMPLE_W-1:0] b_rx_data_p1,
  // chip control
  output logic                a_data_clk,
  output logic                a_resetb,
  output logic                a_enable,
  output logic                a_txnrx,
  output logic                b_data_clk,
  output logic                b_resetb,
  output logic                b_enable,
  output logic                b_txnrx,
  // chip spi
  output logic                a_spi_sck,
  output logic                a_spi_di,
  input  logic                a_spi_do,
  output logic                a_spi_cs,
  output logic                b_spi_sck,
  output logic                b_spi_di,
  input  logic                b_spi_do,
  output logic                b_spi_cs,
  // host side
  input  logic                reset_a,
  input  logic                reset_b,
  input  logic                spi_sck,
  input  logic                spi_mosi,
  output logic                spi_miso,
  input  logic                spi_cs_a,
  input  logic                spi_cs_b,
  // stream out
  output logic                m_axis_tvalid,
  input  logic                m_axis_tready,
  output logic                m_axis_tlast,
  output logic [BEAT_W-1:0]   m_axis_tdata,
  output logic                overflow
);

  // chip a on channels 0/1, chip b on 2/3
  iq_sample_t ch [NUM_CH];

  assign a_data_clk = clk;
  assign b_data_clk = clk;

  rf_ctrl ctrl (.*);

  rx_cmos_if rx_a (
    .clk         (clk),
    .rst         (rst),
    .enable      (a_enable),
    .rx_frame_in (a_rx_frame_in),
    .rx_data_p0  (a_rx_data_p0),
    .rx_data_p1  (a_rx_data_p1),
    .ch_0        (ch[0]),
    .ch_1        (ch[1])
  );

  rx_cmos_if rx_b (
    .clk         (clk),
    .rst         (rst),
    .enable      (b_enable),
    .rx_frame_in (b_rx_frame_in),
    .rx_data_p0  (b_rx_data_p0),
    .rx_data_p1  (b_rx_data_p1),
    .ch_0        (ch[2]),
    .ch_1        (ch[3])
  );

  axis_pack pack (
    .clk           (clk),
    .rst           (rst),
    .ch_in         (ch),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .overflow      (overflow)
  );

endmodule

`default_nettype wire

//--- hdl/axis_pack.sv
`default_nettype none

module axis_pack
  import rf_rx_pkg::*, stream_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  iq_sample_t        ch_in [NUM_CH],
  input  logic              m_axis_tready,
  output logic              m_axis_tvalid,
  output logic [BEAT_W-1:0] m_axis_tdata,
  output logic              m_axis_tlast,
  output logic              overflow
);

  logic [SLOT_W-1:0]     slot [NUM_CH];
  logic [NUM_CH-1:0]     fill;
  logic                  beat_done;
  axis_beat_t            beat;
  axis_beat_t            fifo_mem [FIFO_DEPTH];
  logic [FIFO_AW:0]      wr_ptr;
  logic [FIFO_AW:0]      rd_ptr;
  logic                  fifo_full;
  logic                  fifo_empty;
  logic                  push;
  logic                  pop;
  logic [BEAT_CNT_W-1:0] beat_cnt;

  // 12-bit I and Q to 16 bits each
  function automatic logic [SLOT_W-1:0] pack_slot(input iq_sample_t s);
    return {{(HALF_W - SAMPLE_W){s.i[SAMPLE_W-1]}}, s.i,
            {(HALF_W - SAMPLE_W){s.q[SAMPLE_W-1]}}, s.q};
  endfunction

  //////////////////////////////
  // slot collection

  assign beat_done = &fill;

  // a late sample just overwrites its slot
  always_ff @(posedge clk) begin
    for (int c = 0; c < NUM_CH; c++) begin
      if (ch_in[c].valid) begin
        slot[c] <= pack_slot(ch_in[c]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fill <= '0;
    end else begin
      for (int c = 0; c < NUM_CH; c++) begin
        if (ch_in[c].valid) begin
          fill[c] <= 1'b1;
        end else if (beat_done) begin
          fill[c] <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    beat.last = (beat_cnt == BEAT_CNT_W'(BEATS_PER_PACKET - 1));
    for (int c = 0; c < NUM_CH; c++) begin
      beat.data[(NUM_CH - 1 - c) * SLOT_W +: SLOT_W] = slot[c];
    end
  end

  //////////////////////////////
  // output fifo

  // extra pointer bit tells full from empty
  assign fifo_empty = (wr_ptr == rd_ptr);
  assign fifo_full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                      (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
  assign push = beat_done && !fifo_full;
  assign pop  = m_axis_tvalid && m_axis_tready;

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr[FIFO_AW-1:0]] <= beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      beat_cnt <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr   <= wr_ptr + 1'b1;
        beat_cnt <= beat.last ? '0 : beat_cnt + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // dropped beat, sticky until reset
      if (beat_done && fifo_full) begin
        overflow <= 1'b1;
      end
    end
  end

  assign m_axis_tvalid = !fifo_empty;
  assign m_axis_tdata  = fifo_mem[rd_ptr[FIFO_AW-1:0]].data;
  assign m_axis_tlast  = fifo_mem[rd_ptr[FIFO_AW-1:0]].last;

  // head entry must not move under a stalled sink
  a_stall_hold : assert property (@(posedge clk) disable iff (rst)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast));

endmodule

`default_nettype wire

//--- hdl/rf_ctrl.sv
`default_nettype none

module rf_ctrl
  import rf_rx_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic reset_a,
  input  logic reset_b,
  output logic a_resetb,
  output logic b_resetb,
  output logic a_enable,
  output logic b_enable,
  output logic a_txnrx,
  output logic b_txnrx,
  input  logic spi_sck,
  input  logic spi_mosi,
  input  logic spi_cs_a,
  input  logic spi_cs_b,
  output logic spi_miso,
  output logic a_spi_sck,
  output logic a_spi_di,
  output logic a_spi_cs,
  output logic b_spi_sck,
  output logic b_spi_di,
  output logic b_spi_cs,
  input  logic a_spi_do,
  input  logic b_spi_do
);

  logic [NUM_CHIPS-1:0]    resetb_q;
  logic [NUM_CHIPS-1:0]    enable_q;
  logic [ENABLE_CNT_W-1:0] delay_cnt [NUM_CHIPS];

  //////////////////////////////
  // reset and enable sequencing

  // counter parks one short of the delay, enable follows on the next edge
  always_ff @(posedge clk) begin
    if (rst) begin
      resetb_q <= '0;
      enable_q <= '0;
      for (int c = 0; c < NUM_CHIPS; c++) begin
        delay_cnt[c] <= '0;
      end
    end else begin
      resetb_q <= {reset_b, reset_a};
      for (int c = 0; c < NUM_CHIPS; c++) begin
        if (!resetb_q[c]) begin
          delay_cnt[c] <= '0;
        end else if (delay_cnt[c] != ENABLE_CNT_W'(ENABLE_DELAY - 1)) begin
          delay_cnt[c] <= delay_cnt[c] + 1'b1;
        end
        enable_q[c] <= resetb_q[c] && (delay_cnt[c] == ENABLE_CNT_W'(ENABLE_DELAY - 1));
      end
    end
  end

  assign a_resetb = resetb_q[0];
  assign b_resetb = resetb_q[1];
  assign a_enable = enable_q[0];
  assign b_enable = enable_q[1];

  // receive only
  assign a_txnrx = 1'b0;
  assign b_txnrx = 1'b0;

  //////////////////////////////
  // spi steering

  assign a_spi_cs  = spi_cs_a;
  assign b_spi_cs  = spi_cs_b;
  assign a_spi_sck = spi_sck && !spi_cs_a;
  assign a_spi_di  = spi_mosi && !spi_cs_a;
  assign b_spi_sck = spi_sck && !spi_cs_b;
  assign b_spi_di  = spi_mosi && !spi_cs_b;
  assign spi_miso  = !spi_cs_a ? a_spi_do : (!spi_cs_b ? b_spi_do : 1'b0);

  // both chips would drive miso at once
  a_one_cs : assert property (@(posedge clk) disable iff (rst)
    !(!spi_cs_a && !spi_cs_b));

endmodule

`default_nettype wire

//--- hdl/rf_rx_pkg.sv
`default_nettype none

package rf_rx_pkg;

  //////////////////////////////
  // cmos bus words

  // one I or Q word as the chip drives it on p0 / p1
  localparam int SAMPLE_W = 12;

  // one channel sample after frame pairing
  typedef struct packed {
    logic                valid;
    logic [SAMPLE_W-1:0] i;
    logic [SAMPLE_W-1:0] q;
  } iq_sample_t;

  //////////////////////////////
  // power-up sequencing

  // chips on the board, a and b
  localparam int NUM_CHIPS = 2;

  // cycles from resetb high to enable high
  localparam int ENABLE_DELAY = 16;

  // wide enough to hold ENABLE_DELAY
  localparam int ENABLE_CNT_W = 5;

endpackage

`default_nettype wire

//--- hdl/rx_cmos_if.sv
`default_nettype none

module rx_cmos_if
  import rf_rx_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                enable,
  input  logic                rx_frame_in,
  input  logic [SAMPLE_W-1:0] rx_data_p0,
  input  logic [SAMPLE_W-1:0] rx_data_p1,
  output iq_sample_t          ch_0,
  output iq_sample_t          ch_1
);

  logic                frame_q;
  logic                frame_prev;
  logic [SAMPLE_W-1:0] p0_q;
  logic [SAMPLE_W-1:0] p1_q;
  logic                take_0;
  logic                take_1;

  //////////////////////////////
  // pin capture

  always_ff @(posedge clk) begin
    p0_q <= rx_data_p0;
    p1_q <= rx_data_p1;
    if (rst) begin
      frame_q    <= 1'b0;
      frame_prev <= 1'b0;
    end else begin
      frame_q    <= rx_frame_in;
      frame_prev <= frame_q;
    end
  end

  //////////////////////////////
  // frame pairing

  // frame high is channel 0
  assign take_0 = frame_q;
  // low right after high is channel 1, any other low pair is idle
  assign take_1 = !frame_q && frame_prev;

  always_ff @(posedge clk) begin
    if (take_0) begin
      ch_0.i <= p0_q;
      ch_0.q <= p1_q;
    end
    if (take_1) begin
      ch_1.i <= p0_q;
      ch_1.q <= p1_q;
    end
    if (rst) begin
      ch_0.valid <= 1'b0;
      ch_1.valid <= 1'b0;
    end else begin
      ch_0.valid <= enable && take_0;
      ch_1.valid <= enable && take_1;
    end
  end

  // the packer relies on one strobe per chip per cycle
  a_one_channel : assert property (@(posedge clk) disable iff (rst)
    !(ch_0.valid && ch_1.valid));

endmodule

`default_nettype wire

//--- hdl/stream_pkg.sv
`default_nettype none

package stream_pkg;

  // four channels per beat, channel 0 in the top slot
  localparam int NUM_CH = 4;

  // slot is {I sign-extended, Q sign-extended}
  localparam int SLOT_W = 32;
  localparam int HALF_W = SLOT_W / 2;
  localparam int BEAT_W = NUM_CH * SLOT_W;

  typedef struct packed {
    logic [BEAT_W-1:0] data;
    logic              last;
  } axis_beat_t;

  // output fifo
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW = $clog2(FIFO_DEPTH);

  // tlast period, counted in pushed beats
  localparam int BEATS_PER_PACKET = 8;
  localparam int BEAT_CNT_W = $clog2(BEATS_PER_PACKET);

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the testbench; a failing check ends in $fatal
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_ad9361_dual -f files.f -o sim_tb
./obj_dir/sim_tb

//--- verif/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////
// random source

logic [31:0] lfsr_state = 32'hd6f0476c;

// right-shift galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

function automatic logic rand_bit();
  logic b;
  b = lfsr_state[0];
  lfsr_state = lfsr_step(lfsr_state);
  return b;
endfunction

function automatic logic [SAMPLE_W-1:0] rand_word();
  logic [SAMPLE_W-1:0] w;
  for (int n = 0; n < SAMPLE_W; n++) begin
    w[n] = rand_bit();
  end
  return w;
endfunction

//////////////////////////////
// receive and packing model

logic [SLOT_W-1:0] m_slot [NUM_CH];
logic [NUM_CH-1:0] m_fill = '0;
// frame level each chip drove in the previous cycle
logic [1:0]        m_prev = '0;
int                m_in_pkt = 0;
// stalled sink: fifo space left, beats completed meanwhile
logic              m_stalled = 1'b0;
int                m_keep = 0;
int                m_tries = 0;
axis_beat_t        exp_q [$];

// sign-extended I over sign-extended Q
function automatic logic [SLOT_W-1:0] slot_value(input logic [SAMPLE_W-1:0] i,
                                                 input logic [SAMPLE_W-1:0] q);
  return {HALF_W'($signed(i)), HALF_W'($signed(q))};
endfunction

task automatic model_cycle(input logic fa, input logic [SAMPLE_W-1:0] a0,
                           input logic [SAMPLE_W-1:0] a1, input logic fb,
                           input logic [SAMPLE_W-1:0] b0, input logic [SAMPLE_W-1:0] b1);
  logic [NUM_CH-1:0] hit;
  logic [SLOT_W-1:0] val_a;
  logic [SLOT_W-1:0] val_b;
  axis_beat_t        beat;
  val_a = slot_value(a0, a1);
  val_b = slot_value(b0, b1);
  // high gives the first channel, low right after high the second
  hit = {!fb && m_prev[1], fb, !fa && m_prev[0], fa};
  if (&m_fill) begin
    if (m_stalled) begin
      m_tries++;
    end
    if (!m_stalled || m_keep > 0) begin
      if (m_stalled) begin
        m_keep--;
      end
      m_in_pkt++;
      beat.data = {m_slot[0], m_slot[1], m_slot[2], m_slot[3]};
      beat.last = (m_in_pkt == BEATS_PER_PACKET);
      if (beat.last) begin
        m_in_pkt = 0;
      end
      exp_q.push_back(beat);
    end
    m_fill = '0;
  end
  for (int c = 0; c < NUM_CH; c++) begin
    if (hit[c]) begin
      m_slot[c] = (c < 2) ? val_a : val_b;
      m_fill[c] = 1'b1;
    end
  end
  m_prev = {fb, fa};
endtask

`endif

//--- verif/tb_ad9361_dual.sv
`default_nettype none

module tb_ad9361_dual
  import rf_rx_pkg::*, stream_pkg::*;
();

  localparam int RESET_CYC       = 2;
  localparam int ENABLE_WAIT_MAX = ENABLE_DELAY + 8;
  localparam int ALIGNED_CYC     = 240;
  localparam int SKEW_CYC        = 40;
  localparam int RANDOM_CYC      = 240;
  localparam int DRAIN_MAX       = 64;
  localparam int STALL_CYC       = 40;
  localparam int SETTLE_CYC      = 8;
  localparam int SPI_CYC         = 32;
  localparam int TOTAL_CYC = RESET_CYC + ENABLE_WAIT_MAX + 1 + ALIGNED_CYC + SKEW_CYC
                           + RANDOM_CYC + 2 * (DRAIN_MAX + 1) + STALL_CYC + SETTLE_CYC
                           + SPI_CYC;
  localparam int WATCHDOG_T = TOTAL_CYC * 4 * 3;

  logic clk;
  logic rst;
  logic a_rx_frame_in;
  logic [SAMPLE_W-1:0] a_rx_data_p0;
  logic [SAMPLE_W-1:0] a_rx_data_p1;
  logic b_rx_frame_in;
  logic [SAMPLE_W-1:0] b_rx_data_p0;
  logic [SAMPLE_W-1:0] b_rx_data_p1;
  logic a_data_clk;
  logic a_resetb;
  logic a_enable;
  logic a_txnrx;
  logic b_data_clk;
  logic b_resetb;
  logic b_enable;
  logic b_txnrx;
  logic a_spi_sck;
  logic a_spi_di;
  logic a_spi_do;
  logic a_spi_cs;
  logic b_spi_sck;
  logic b_spi_di;
  logic b_spi_do;
  logic b_spi_cs;
  logic reset_a;
  logic reset_b;
  logic spi_sck;
  logic spi_mosi;
  logic spi_miso;
  logic spi_cs_a;
  logic spi_cs_b;
  logic m_axis_tvalid;
  logic m_axis_tready;
  logic m_axis_tlast;
  logic [BEAT_W-1:0] m_axis_tdata;
  logic overflow;
  int   rx_beats = 0;

  `include "tb_model.svh"

  ad9361_dual uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_T);
    $display("watchdog expired before the test sequence finished");
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

  //////////////////////////////
  // error reporting

  task automatic value_error(input string name, input logic [BEAT_W-1:0] got,
                             input logic [BEAT_W-1:0] want);
    $display("ERR t=%0t %s got %0h expected %0h", $time, name, got, want);
    $display("TEST RESULT: FAIL");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_problem(input string msg);
    $display("t=%0t %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    assert (got === want) else value_error(name, BEAT_W'(got), BEAT_W'(want));
  endtask

  //////////////////////////////
  // stimulus

  task automatic apply_cycle(input logic fa, input logic [SAMPLE_W-1:0] a0,
                             input logic [SAMPLE_W-1:0] a1, input logic fb,
                             input logic [SAMPLE_W-1:0] b0, input logic [SAMPLE_W-1:0] b1,
                             input logic rdy);
    axis_beat_t want;
    @(negedge clk);
    a_rx_frame_in = fa;
    a_rx_data_p0  = a0;
    a_rx_data_p1  = a1;
    b_rx_frame_in = fb;
    b_rx_data_p0  = b0;
    b_rx_data_p1  = b1;
    m_axis_tready = rdy;
    model_cycle(fa, a0, a1, fb, b0, b1);
    // this beat transfers on the coming rising edge
    if (m_axis_tvalid && m_axis_tready) begin
      assert (exp_q.size() > 0) else report_problem("stream beat arrived with none expected");
      want = exp_q.pop_front();
      rx_beats++;
      assert (m_axis_tdata === want.data)
        else value_error("m_axis_tdata", m_axis_tdata, want.data);
      check_bit("m_axis_tlast", m_axis_tlast, want.last);
    end
  endtask

  task automatic idle_cycle(input logic rdy);
    apply_cycle(1'b0, '0, '0, 1'b0, '0, '0, rdy);
  endtask

  task automatic random_cycle(input logic fa, input logic fb, input logic rdy);
    logic [SAMPLE_W-1:0] w [4];
    for (int n = 0; n < 4; n++) begin
      w[n] = rand_word();
    end
    apply_cycle(fa, w[0], w[1], fb, w[2], w[3], rdy);
  endtask

  // mode 0 aligned, 1 chip b one cycle behind, 2 random frames
  task automatic run_frames(input int cycles, input int mode);
    logic rdy;
    logic fa;
    logic fb;
    rdy = 1'b1;
    for (int n = 0; n < cycles; n++) begin
      // sink takes a beat at least every second cycle
      rdy = rand_bit() || !rdy;
      fa = (n % 2 == 0);
      fb = (mode == 1) ? !fa : fa;
      if (mode == 2) begin
        fa = rand_bit();
        fb = rand_bit();
      end
      random_cycle(fa, fb, rdy);
      check_bit("overflow", overflow, 1'b0);
    end
  endtask

  task automatic drain_stream();
    int n;
    n = 0;
    idle_cycle(1'b1);
    while ((exp_q.size() > 0 || m_axis_tvalid) && n < DRAIN_MAX) begin
      idle_cycle(1'b1);
      n++;
    end
    assert (exp_q.size() == 0 && !m_axis_tvalid)
      else report_problem("stream did not drain the expected beats");
  endtask

  //////////////////////////////
  // test sequence

  initial begin
    int   k;
    int   beats_before;
    logic sel;
    rst = 1'b1;
    a_rx_frame_in = 1'b0;
    a_rx_data_p0 = '0;
    a_rx_data_p1 = '0;
    b_rx_frame_in = 1'b0;
    b_rx_data_p0 = '0;
    b_rx_data_p1 = '0;
    a_spi_do = 1'b0;
    b_spi_do = 1'b0;
    reset_a = 1'b0;
    reset_b = 1'b0;
    spi_sck = 1'b0;
    spi_mosi = 1'b0;
    spi_cs_a = 1'b1;
    spi_cs_b = 1'b1;
    m_axis_tready = 1'b1;
    repeat (RESET_CYC) @(negedge clk);
    rst = 1'b0;

    // reset and enable sequencing
    idle_cycle(1'b1);
    reset_a = 1'b1;
    reset_b = 1'b1;
    k = 0;
    while (!(a_enable && b_enable) && k < ENABLE_WAIT_MAX) begin
      idle_cycle(1'b1);
      k++;
      if (k == 1) begin
        assert (a_resetb && b_resetb) else report_problem("resetb did not follow after one cycle");
      end
      assert (!m_axis_tvalid && !overflow && !a_txnrx && !b_txnrx)
        else report_problem("stream, overflow or txnrx active during power-up");
    end
    assert (k == ENABLE_DELAY + 1)
      else value_error("enable delay", BEAT_W'(k), BEAT_W'(ENABLE_DELAY + 1));

    // aligned, skewed and random frames
    run_frames(ALIGNED_CYC, 0);
    run_frames(SKEW_CYC, 1);
    run_frames(RANDOM_CYC, 2);
    drain_stream();
    assert (rx_beats >= 2 * BEATS_PER_PACKET) else report_problem("too few beats for tlast");

    // stalled sink
    m_stalled = 1'b1;
    m_keep = FIFO_DEPTH;
    m_tries = 0;
    for (int n = 0; n < STALL_CYC; n++) begin
      random_cycle(n % 2 == 0, n % 2 == 0, 1'b0);
    end
    repeat (SETTLE_CYC) idle_cycle(1'b0);
    assert (m_tries >= FIFO_DEPTH + 2) else report_problem("too few beats completed in stall");
    check_bit("overflow", overflow, 1'b1);
    m_stalled = 1'b0;
    beats_before = rx_beats;
    drain_stream();
    assert (rx_beats - beats_before == FIFO_DEPTH)
      else value_error("beats after stall", BEAT_W'(rx_beats - beats_before),
                       BEAT_W'(FIFO_DEPTH));

    // spi steering, sel low picks chip a
    for (int n = 0; n < SPI_CYC; n++) begin
      @(negedge clk);
      sel = rand_bit();
      spi_cs_a = sel;
      spi_cs_b = !sel;
      spi_sck = rand_bit();
      spi_mosi = rand_bit();
      a_spi_do = rand_bit();
      b_spi_do = rand_bit();
      #1;
      // data clocks follow clk, low half here
      check_bit("a_data_clk", a_data_clk, 1'b0);
      check_bit("b_data_clk", b_data_clk, 1'b0);
      @(posedge clk);
      check_bit("a_spi_sck", a_spi_sck, sel ? 1'b0 : spi_sck);
      check_bit("a_spi_di", a_spi_di, sel ? 1'b0 : spi_mosi);
      check_bit("b_spi_sck", b_spi_sck, sel ? spi_sck : 1'b0);
      check_bit("b_spi_di", b_spi_di, sel ? spi_mosi : 1'b0);
      check_bit("a_spi_cs", a_spi_cs, sel);
      check_bit("b_spi_cs", b_spi_cs, !sel);
      check_bit("spi_miso", spi_miso, sel ? b_spi_do : a_spi_do);
      #1;
      check_bit("a_data_clk", a_data_clk, 1'b1);
      check_bit("b_data_clk", b_data_clk, 1'b1);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
